/* Makefile */
TOOL       ?= verilator
TOP        ?= tb_img_capture
RTL_TOP    ?= img_capture_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS ?= --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation ended without result"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/img_capture_ctrl.sv */
`timescale 1ns/1ps

module img_capture_ctrl #(
    parameter int  IMG_WIDTH_MAX  = 16,
    parameter int  IMG_HEIGHT_MAX = 16,
    parameter int  HEADER_WIDTH   = 64,
    localparam int W_W         = $clog2(IMG_WIDTH_MAX + 1),
    localparam int H_W         = $clog2(IMG_HEIGHT_MAX + 1),
    localparam int HDR_WORDS   = HEADER_WIDTH / 16,
    localparam int BLOCK_WORDS = HDR_WORDS + IMG_WIDTH_MAX * IMG_HEIGHT_MAX,
    localparam int ADDR_W      = $clog2(2 * BLOCK_WORDS),
    localparam int CNT_W       = $clog2(BLOCK_WORDS + 1)
) (
    input  logic                       clk,
    input  logic                       fifoIn_rst,

    input  logic                       capture_start,
    input  logic [HEADER_WIDTH-1:0]    header,
    input  logic                       ram_block,

    input  logic                       px_valid,
    input  logic [img_pkg::WORD_W-1:0] px_data,
    input  logic                       frame_done,
    input  logic [W_W-1:0]             meas_width,
    input  logic [H_W-1:0]             meas_height,

    output logic                       arm,
    output logic                       wr_en,
    output logic [ADDR_W-1:0]          wr_addr,
    output logic [img_pkg::WORD_W-1:0] wr_data,
    output logic                       results_valid,

    output logic                       read_start,
    output logic [ADDR_W-1:0]          read_base,
    output logic [CNT_W-1:0]           read_count
);

    import img_pkg::*;

    ctrl_state_t                    state;
    logic [HEADER_WIDTH-1:0]        hdr_shift;
    logic [$clog2(HDR_WORDS+1)-1:0] hdr_cnt;
    logic [ADDR_W-1:0]              wr_ptr;
    logic [ADDR_W-1:0]              blk_base;

    // ====================
    // Write port
    // ====================
    always_comb begin
        wr_en   = (state == CTRL_HEADER) || ((state == CTRL_CAPTURE) && px_valid);
        wr_addr = wr_ptr;
        wr_data = (state == CTRL_HEADER) ? hdr_shift[HEADER_WIDTH-1 -: WORD_W] : px_data;
    end

    assign arm           = (state == CTRL_ARM);
    assign results_valid = (state == CTRL_CAPTURE) && frame_done;

    // Header words leave most significant first
    always_ff @(posedge clk) begin
        if (capture_start)
            hdr_shift <= header;
        else if (state == CTRL_HEADER)
            hdr_shift <= hdr_shift << WORD_W;
    end

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state      <= CTRL_IDLE;
            hdr_cnt    <= '0;
            wr_ptr     <= '0;
            blk_base   <= '0;
            read_start <= 1'b0;
            read_base  <= '0;
            read_count <= '0;
        end else begin
            read_start <= 1'b0;
            if (capture_start) begin
                // Restart from any state, an empty read idles the readout
                state      <= CTRL_HEADER;
                hdr_cnt    <= '0;
                blk_base   <= ram_block ? ADDR_W'(BLOCK_WORDS) : '0;
                wr_ptr     <= ram_block ? ADDR_W'(BLOCK_WORDS) : '0;
                read_start <= 1'b1;
                read_count <= '0;
            end else begin
                case (state)
                    CTRL_HEADER: begin
                        wr_ptr  <= wr_ptr + 1'b1;
                        hdr_cnt <= hdr_cnt + 1'b1;
                        if (hdr_cnt == HDR_WORDS - 1)
                            state <= CTRL_ARM;
                    end
                    CTRL_ARM: state <= CTRL_CAPTURE;
                    CTRL_CAPTURE: begin
                        if (px_valid)
                            wr_ptr <= wr_ptr + 1'b1;
                        if (frame_done) begin
                            state      <= CTRL_READ_START;
                            read_start <= 1'b1;
                            read_base  <= blk_base;
                            read_count <= CNT_W'(HDR_WORDS)
                                        + CNT_W'(meas_width) * CNT_W'(meas_height);
                        end
                    end
                    CTRL_READ_START: state <= CTRL_READOUT;
                    // Readout runs on its own until the next command
                    default: ;
                endcase
            end
        end
    end

    // Pixel capture is only armed once the header is written
    a_hdr_no_pixel: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (state == CTRL_HEADER) |-> !px_valid);

endmodule

/* hdl/img_capture_top.sv */
`timescale 1ns/1ps

module img_capture_top #(
    parameter int  IMG_WIDTH_MAX  = 16,
    parameter int  IMG_HEIGHT_MAX = 16,
    parameter int  HEADER_WIDTH   = 64,
    localparam int W_W = $clog2(IMG_WIDTH_MAX + 1),
    localparam int H_W = $clog2(IMG_HEIGHT_MAX + 1)
) (
    input  logic                        clk,
    input  logic                        fifoIn_rst,

    input  logic                        cmd_capture,
    input  logic                        cmd_ram_block,
    input  logic [HEADER_WIDTH-1:0]     cmd_header,

    input  logic [img_pkg::PIXEL_W-1:0] img_d,
    input  logic                        img_fv,
    input  logic                        img_lv,

    output logic                        status_capture_done,
    output logic [W_W-1:0]              status_image_width,
    output logic [H_W-1:0]              status_image_height,
    output logic [img_pkg::STAT_W-1:0]  status_highlight_count,
    output logic [img_pkg::STAT_W-1:0]  status_shadow_count,

    output logic                        readout_ready,
    input  logic                        readout_trigger,
    output logic [img_pkg::WORD_W-1:0]  readout_data
);

    import img_pkg::*;

    localparam int BLOCK_WORDS = HEADER_WIDTH / 16 + IMG_WIDTH_MAX * IMG_HEIGHT_MAX;
    localparam int ADDR_W      = $clog2(2 * BLOCK_WORDS);
    localparam int CNT_W       = $clog2(BLOCK_WORDS + 1);

    logic                    capture_start;
    logic [HEADER_WIDTH-1:0] header;
    logic                    ram_block;
    logic                    arm;
    logic                    px_valid;
    logic [WORD_W-1:0]       px_data;
    logic                    frame_done;
    logic [W_W-1:0]          meas_width;
    logic [H_W-1:0]          meas_height;
    logic [STAT_W-1:0]       meas_highlight;
    logic [STAT_W-1:0]       meas_shadow;
    logic                    results_valid;
    logic                    wr_en;
    logic [ADDR_W-1:0]       wr_addr;
    logic [WORD_W-1:0]       wr_data;
    logic                    rd_en;
    logic [ADDR_W-1:0]       rd_addr;
    logic [WORD_W-1:0]       rd_data;
    logic                    read_start;
    logic [ADDR_W-1:0]       read_base;
    logic [CNT_W-1:0]        read_count;

    img_cmd_regs #(
        .IMG_WIDTH_MAX (IMG_WIDTH_MAX),
        .IMG_HEIGHT_MAX(IMG_HEIGHT_MAX),
        .HEADER_WIDTH  (HEADER_WIDTH)
    ) u_cmd_regs (
        .clk                   (clk),
        .fifoIn_rst            (fifoIn_rst),
        .cmd_capture           (cmd_capture),
        .cmd_ram_block         (cmd_ram_block),
        .cmd_header            (cmd_header),
        .meas_width            (meas_width),
        .meas_height           (meas_height),
        .meas_highlight        (meas_highlight),
        .meas_shadow           (meas_shadow),
        .results_valid         (results_valid),
        .capture_start         (capture_start),
        .header                (header),
        .ram_block             (ram_block),
        .status_capture_done   (status_capture_done),
        .status_image_width    (status_image_width),
        .status_image_height   (status_image_height),
        .status_highlight_count(status_highlight_count),
        .status_shadow_count   (status_shadow_count)
    );

    img_pixel_capture #(
        .IMG_WIDTH_MAX (IMG_WIDTH_MAX),
        .IMG_HEIGHT_MAX(IMG_HEIGHT_MAX)
    ) u_pixel_capture (
        .clk           (clk),
        .fifoIn_rst    (fifoIn_rst),
        .arm           (arm),
        .img_d         (img_d),
        .img_fv        (img_fv),
        .img_lv        (img_lv),
        .px_valid      (px_valid),
        .px_data       (px_data),
        .frame_done    (frame_done),
        .meas_width    (meas_width),
        .meas_height   (meas_height),
        .meas_highlight(meas_highlight),
        .meas_shadow   (meas_shadow)
    );

    img_frame_buffer #(
        .IMG_WIDTH_MAX (IMG_WIDTH_MAX),
        .IMG_HEIGHT_MAX(IMG_HEIGHT_MAX),
        .HEADER_WIDTH  (HEADER_WIDTH)
    ) u_frame_buffer (
        .clk    (clk),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    img_capture_ctrl #(
        .IMG_WIDTH_MAX (IMG_WIDTH_MAX),
        .IMG_HEIGHT_MAX(IMG_HEIGHT_MAX),
        .HEADER_WIDTH  (HEADER_WIDTH)
    ) u_capture_ctrl (
        .clk          (clk),
        .fifoIn_rst   (fifoIn_rst),
        .capture_start(capture_start),
        .header       (header),
        .ram_block    (ram_block),
        .px_valid     (px_valid),
        .px_data      (px_data),
        .frame_done   (frame_done),
        .meas_width   (meas_width),
        .meas_height  (meas_height),
        .arm          (arm),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .results_valid(results_valid),
        .read_start   (read_start),
        .read_base    (read_base),
        .read_count   (read_count)
    );

    img_readout #(
        .IMG_WIDTH_MAX (IMG_WIDTH_MAX),
        .IMG_HEIGHT_MAX(IMG_HEIGHT_MAX),
        .HEADER_WIDTH  (HEADER_WIDTH)
    ) u_readout (
        .clk            (clk),
        .fifoIn_rst     (fifoIn_rst),
        .read_start     (read_start),
        .read_base      (read_base),
        .read_count     (read_count),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .readout_ready  (readout_ready),
        .readout_trigger(readout_trigger),
        .readout_data   (readout_data)
    );

endmodule

/* hdl/img_cmd_regs.sv */
`timescale 1ns/1ps

module img_cmd_regs #(
    parameter int  IMG_WIDTH_MAX  = 16,
    parameter int  IMG_HEIGHT_MAX = 16,
    parameter int  HEADER_WIDTH   = 64,
    localparam int W_W = $clog2(IMG_WIDTH_MAX + 1),
    localparam int H_W = $clog2(IMG_HEIGHT_MAX + 1)
) (
    input  logic                        clk,
    input  logic                        fifoIn_rst,

    input  logic                        cmd_capture,
    input  logic                        cmd_ram_block,
    input  logic [HEADER_WIDTH-1:0]     cmd_header,

    input  logic [W_W-1:0]              meas_width,
    input  logic [H_W-1:0]              meas_height,
    input  logic [img_pkg::STAT_W-1:0]  meas_highlight,
    input  logic [img_pkg::STAT_W-1:0]  meas_shadow,
    input  logic                        results_valid,

    output logic                        capture_start,
    output logic [HEADER_WIDTH-1:0]     header,
    output logic                        ram_block,

    output logic                        status_capture_done,
    output logic [W_W-1:0]              status_image_width,
    output logic [H_W-1:0]              status_image_height,
    output logic [img_pkg::STAT_W-1:0]  status_highlight_count,
    output logic [img_pkg::STAT_W-1:0]  status_shadow_count
);

    // Command latch, held until the next capture command
    always_ff @(posedge clk) begin
        if (cmd_capture) begin
            header    <= cmd_header;
            ram_block <= cmd_ram_block;
        end
    end

    // Status registers only change when a capture completes
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            capture_start          <= 1'b0;
            status_capture_done    <= 1'b0;
            status_image_width     <= '0;
            status_image_height    <= '0;
            status_highlight_count <= '0;
            status_shadow_count    <= '0;
        end else begin
            capture_start       <= cmd_capture;
            status_capture_done <= results_valid;
            if (results_valid) begin
                status_image_width     <= meas_width;
                status_image_height    <= meas_height;
                status_highlight_count <= meas_highlight;
                status_shadow_count    <= meas_shadow;
            end
        end
    end

endmodule

/* hdl/img_frame_buffer.sv */
`timescale 1ns/1ps

module img_frame_buffer #(
    parameter int  IMG_WIDTH_MAX  = 16,
    parameter int  IMG_HEIGHT_MAX = 16,
    parameter int  HEADER_WIDTH   = 64,
    localparam int BLOCK_WORDS = HEADER_WIDTH / 16 + IMG_WIDTH_MAX * IMG_HEIGHT_MAX,
    localparam int ADDR_W      = $clog2(2 * BLOCK_WORDS)
) (
    input  logic                       clk,

    input  logic                       wr_en,
    input  logic [ADDR_W-1:0]          wr_addr,
    input  logic [img_pkg::WORD_W-1:0] wr_data,

    input  logic                       rd_en,
    input  logic [ADDR_W-1:0]          rd_addr,
    output logic [img_pkg::WORD_W-1:0] rd_data
);

    import img_pkg::*;

    // Block 0 starts at word 0, block 1 at BLOCK_WORDS
    logic [WORD_W-1:0] mem [2 * BLOCK_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

    // Sequencers must stay inside the two blocks
    a_wr_range: assert property (@(posedge clk)
        wr_en |-> (int'(wr_addr) < 2 * BLOCK_WORDS));
    a_rd_range: assert property (@(posedge clk)
        rd_en |-> (int'(rd_addr) < 2 * BLOCK_WORDS));

endmodule

/* hdl/img_pixel_capture.sv */
`timescale 1ns/1ps

module img_pixel_capture #(
    parameter int  IMG_WIDTH_MAX  = 16,
    parameter int  IMG_HEIGHT_MAX = 16,
    localparam int W_W = $clog2(IMG_WIDTH_MAX + 1),
    localparam int H_W = $clog2(IMG_HEIGHT_MAX + 1)
) (
    input  logic                        clk,
    input  logic                        fifoIn_rst,
    input  logic                        arm,

    input  logic [img_pkg::PIXEL_W-1:0] img_d,
    input  logic                        img_fv,
    input  logic                        img_lv,

    output logic                        px_valid,
    output logic [img_pkg::WORD_W-1:0]  px_data,
    output logic                        frame_done,

    output logic [W_W-1:0]              meas_width,
    output logic [H_W-1:0]              meas_height,
    output logic [img_pkg::STAT_W-1:0]  meas_highlight,
    output logic [img_pkg::STAT_W-1:0]  meas_shadow
);

    import img_pkg::*;

    cap_state_t             state;
    logic                   px_take;
    logic                   lv_prev;
    logic [SAMPLE_BITS-1:0] col;
    logic [SAMPLE_BITS-1:0] row;
    logic                   stat_en;
    logic [PIXEL_W-1:0]     stat_px;

    // A pixel is stored while both valids are high in the active frame
    assign px_take = (state == CAP_ACTIVE) && img_fv && img_lv;

    // Pixel word and the copy used by the tone test one cycle later
    always_ff @(posedge clk) begin
        px_data <= {{(WORD_W - PIXEL_W){1'b0}}, img_d};
        stat_px <= img_d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state          <= CAP_IDLE;
            px_valid       <= 1'b0;
            frame_done     <= 1'b0;
            lv_prev        <= 1'b0;
            col            <= '0;
            row            <= '0;
            stat_en        <= 1'b0;
            meas_width     <= '0;
            meas_height    <= '0;
            meas_highlight <= '0;
            meas_shadow    <= '0;
        end else begin
            px_valid   <= px_take;
            frame_done <= 1'b0;
            lv_prev    <= img_lv;

            // ====================
            // Image size
            // ====================
            if (px_take) begin
                if (!lv_prev) begin
                    meas_width  <= W_W'(1);
                    meas_height <= meas_height + 1'b1;
                end else begin
                    meas_width  <= meas_width + 1'b1;
                end
            end

            // ====================
            // Sampling grid and tone statistics
            // ====================
            col <= img_lv ? col + 1'b1 : '0;
            if (!img_fv)
                row <= '0;
            else if (lv_prev && !img_lv)
                row <= row + 1'b1;

            stat_en <= px_take && (col == '0) && (row == '0);
            if (stat_en) begin
                if (stat_px[PIXEL_W-1 -: TONE_BITS] == TONE_HIGHLIGHT)
                    meas_highlight <= meas_highlight + 1'b1;
                else if (stat_px[PIXEL_W-1 -: TONE_BITS] == TONE_SHADOW)
                    meas_shadow <= meas_shadow + 1'b1;
            end

            // Frame sync
            case (state)
                CAP_WAIT_INVALID: if (!img_fv) state <= CAP_WAIT_START;
                CAP_WAIT_START:   if (img_fv) state <= CAP_ACTIVE;
                CAP_ACTIVE: begin
                    if (!img_fv) begin
                        state      <= CAP_IDLE;
                        frame_done <= 1'b1;
                    end
                end
                default: ;
            endcase

            // Arming restarts the sequence with fresh measurements
            if (arm) begin
                state          <= CAP_WAIT_INVALID;
                meas_width     <= '0;
                meas_height    <= '0;
                meas_highlight <= '0;
                meas_shadow    <= '0;
            end
        end
    end

    // No pixel strobe outside the active frame
    a_px_valid_active: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        px_valid |-> (state == CAP_ACTIVE));

endmodule

/* hdl/img_pkg.sv */
package img_pkg;

    // ====================
    // Data widths
    // ====================
    localparam int PIXEL_W     = 12;
    localparam int WORD_W      = 16;
    localparam int STAT_W      = 18;

    // Top pixel bits examined by the tone test
    localparam int TONE_BITS   = 7;

    // Wrapping column/row counters, sample when both are zero
    localparam int SAMPLE_BITS = 2;

    // Tone codes for the top pixel bits
    localparam logic [TONE_BITS-1:0] TONE_HIGHLIGHT = '1;
    localparam logic [TONE_BITS-1:0] TONE_SHADOW    = '0;

    // ====================
    // State encodings
    // ====================
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_HEADER,
        CTRL_ARM,
        CTRL_CAPTURE,
        CTRL_READ_START,
        CTRL_READOUT
    } ctrl_state_t;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_INVALID,
        CAP_WAIT_START,
        CAP_ACTIVE
    } cap_state_t;

endpackage

/* hdl/img_readout.sv */
`timescale 1ns/1ps

module img_readout #(
    parameter int  IMG_WIDTH_MAX  = 16,
    parameter int  IMG_HEIGHT_MAX = 16,
    parameter int  HEADER_WIDTH   = 64,
    localparam int BLOCK_WORDS = HEADER_WIDTH / 16 + IMG_WIDTH_MAX * IMG_HEIGHT_MAX,
    localparam int ADDR_W      = $clog2(2 * BLOCK_WORDS),
    localparam int CNT_W       = $clog2(BLOCK_WORDS + 1)
) (
    input  logic                       clk,
    input  logic                       fifoIn_rst,

    input  logic                       read_start,
    input  logic [ADDR_W-1:0]          read_base,
    input  logic [CNT_W-1:0]           read_count,

    output logic                       rd_en,
    output logic [ADDR_W-1:0]          rd_addr,
    input  logic [img_pkg::WORD_W-1:0] rd_data,

    output logic                       readout_ready,
    input  logic                       readout_trigger,
    output logic [img_pkg::WORD_W-1:0] readout_data
);

    logic [CNT_W-1:0] fetch_left;
    logic             pending;

    // One word in flight at most, fetched once the output register frees up
    assign rd_en = !read_start && (fetch_left != '0) && !pending
                && (!readout_ready || readout_trigger);

    always_ff @(posedge clk) begin
        if (pending)
            readout_data <= rd_data;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            rd_addr       <= '0;
            fetch_left    <= '0;
            pending       <= 1'b0;
            readout_ready <= 1'b0;
        end else if (read_start) begin
            rd_addr       <= read_base;
            fetch_left    <= read_count;
            pending       <= 1'b0;
            readout_ready <= 1'b0;
        end else begin
            pending <= rd_en;
            if (rd_en) begin
                rd_addr    <= rd_addr + 1'b1;
                fetch_left <= fetch_left - 1'b1;
            end
            if (pending)
                readout_ready <= 1'b1;
            else if (readout_trigger)
                readout_ready <= 1'b0;
        end
    end

    // Back-pressure rule of the readout port
    a_stall_hold: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (readout_ready && !readout_trigger) |=> $stable(readout_data));

endmodule

/* src.f */
hdl/img_pkg.sv
hdl/img_cmd_regs.sv
hdl/img_pixel_capture.sv
hdl/img_frame_buffer.sv
hdl/img_capture_ctrl.sv
hdl/img_readout.sv
hdl/img_capture_top.sv
verif/tb_img_capture.sv

/* verif/tb_img_capture.sv */
`timescale 1ns/1ps

module tb_img_capture;

    import img_pkg::*;

    localparam int IMG_WIDTH_MAX  = 16;
    localparam int IMG_HEIGHT_MAX = 16;
    localparam int HEADER_WIDTH   = 64;
    localparam int HDR_WORDS      = HEADER_WIDTH / 16;
    localparam int W_W            = $clog2(IMG_WIDTH_MAX + 1);
    localparam int H_W            = $clog2(IMG_HEIGHT_MAX + 1);
    localparam int N_CASES        = 5;

    // One row of the stimulus table
    typedef struct packed {
        logic                    blk;
        logic [HEADER_WIDTH-1:0] hdr;
        int                      w;
        int                      h;
        int                      gap;
        logic                    tone;
        int                      abort_after;
    } case_t;

    logic                    clk = 1'b0;
    logic                    fifoIn_rst;
    logic                    cmd_capture;
    logic                    cmd_ram_block;
    logic [HEADER_WIDTH-1:0] cmd_header;
    logic [PIXEL_W-1:0]      img_d;
    logic                    img_fv;
    logic                    img_lv;
    logic                    readout_trigger;
    logic                    status_capture_done;
    logic [W_W-1:0]          status_image_width;
    logic [H_W-1:0]          status_image_height;
    logic [STAT_W-1:0]       status_highlight_count;
    logic [STAT_W-1:0]       status_shadow_count;
    logic                    readout_ready;
    logic [WORD_W-1:0]       readout_data;

    case_t             cases [N_CASES];
    logic [WORD_W-1:0] exp_q [$];
    int                exp_hi;
    int                exp_sh;
    int                seed     = 32'he5980c52;
    int                n_checks = 0;
    int                n_errors = 0;
    int                cycles   = 0;
    int                limit    = 32'h7fff_ffff;

    img_capture_top #(
        .IMG_WIDTH_MAX (IMG_WIDTH_MAX),
        .IMG_HEIGHT_MAX(IMG_HEIGHT_MAX),
        .HEADER_WIDTH  (HEADER_WIDTH)
    ) u_dut (
        .clk                   (clk),
        .fifoIn_rst            (fifoIn_rst),
        .cmd_capture           (cmd_capture),
        .cmd_ram_block         (cmd_ram_block),
        .cmd_header            (cmd_header),
        .img_d                 (img_d),
        .img_fv                (img_fv),
        .img_lv                (img_lv),
        .status_capture_done   (status_capture_done),
        .status_image_width    (status_image_width),
        .status_image_height   (status_image_height),
        .status_highlight_count(status_highlight_count),
        .status_shadow_count   (status_shadow_count),
        .readout_ready         (readout_ready),
        .readout_trigger       (readout_trigger),
        .readout_data          (readout_data)
    );

    always #20 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles (checks %0d, errors %0d)",
                     limit, n_checks, n_errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_val(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[FAIL] %0t: %s, got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    // ====================
    // Pixel sources
    // ====================
    // Highlight, shadow and mid tones spread over the sampling grid
    function automatic logic [PIXEL_W-1:0] tone_pixel(input int k, input int j);
        case ((k + j) % 3)
            0:       return 12'hFE0 + 12'(j);
            1:       return 12'h010 + 12'(k);
            default: return 12'h7A5;
        endcase
    endfunction

    // Biased toward the two tone classes so the counters move
    function automatic logic [PIXEL_W-1:0] random_pixel();
        logic [31:0] r;
        r = $random(seed);
        case (r[14:13])
            2'd0:    return {7'h7F, r[4:0]};
            2'd1:    return {7'h00, r[4:0]};
            default: return r[11:0];
        endcase
    endfunction

    function automatic int case_cycles(input case_t c);
        return 32 + 2 * c.gap + 9 + c.h * (c.w + c.gap) + 2 * (HDR_WORDS + c.w * c.h);
    endfunction

    task automatic load_cases();
        cases[0] = '{1'b0, 64'h1234_5678_9ABC_DEF0, 8, 6, 2, 1'b1, 0};
        cases[1] = '{1'b1, 64'hCAFE_0001_BEEF_0002, 16, 16, 3, 1'b0, 0};
        // Readout is cut short, the next command lands mid-readout
        cases[2] = '{1'b0, 64'h0F0F_F0F0_5A5A_A5A5, 5, 9, 1, 1'b0, 7};
        cases[3] = '{1'b1, 64'h0000_1111_2222_3333, 12, 4, 2, 1'b1, 0};
        cases[4] = '{1'b0, 64'h8001_4002_2003_1004, 4, 13, 1, 1'b0, 0};
    endtask

    // ====================
    // Sensor model
    // ====================
    // Frame already running when the command arrives, it must not be captured
    task automatic skip_frame_with_cmd(input case_t c);
        @(posedge clk);
        img_fv        <= 1'b1;
        img_lv        <= 1'b0;
        cmd_ram_block <= c.blk;
        cmd_header    <= c.hdr;
        for (int ln = 0; ln < 3; ln++) begin
            for (int j = 0; j < 6; j++) begin
                @(posedge clk);
                img_lv <= 1'b1;
                img_d  <= 12'hFFF;
            end
            for (int g = 0; g < 3; g++) begin
                @(posedge clk);
                img_lv      <= 1'b0;
                cmd_capture <= (ln == 0) && (g == 0);
            end
        end
        @(negedge clk);
        check_val(readout_ready, 1'b0, "readout idle after capture command");
    endtask

    task automatic drive_frame(input case_t c);
        logic [PIXEL_W-1:0] pix;
        repeat (c.gap + 1) begin
            @(posedge clk);
            img_fv <= 1'b0;
            img_lv <= 1'b0;
        end
        for (int k = 0; k < c.h; k++) begin
            repeat (c.gap) begin
                @(posedge clk);
                img_fv <= 1'b1;
                img_lv <= 1'b0;
            end
            for (int j = 0; j < c.w; j++) begin
                pix = c.tone ? tone_pixel(k, j) : random_pixel();
                @(posedge clk);
                img_lv <= 1'b1;
                img_d  <= pix;
                exp_q.push_back({{(WORD_W - PIXEL_W){1'b0}}, pix});
                // Grid point every fourth column of every fourth row
                if ((k % 4 == 0) && (j % 4 == 0)) begin
                    if (pix[PIXEL_W-1 -: 7] == 7'h7F)
                        exp_hi++;
                    else if (pix[PIXEL_W-1 -: 7] == 7'h00)
                        exp_sh++;
                end
            end
        end
        repeat (c.gap) begin
            @(posedge clk);
            img_lv <= 1'b0;
        end
        @(posedge clk);
        img_fv <= 1'b0;
    endtask

    // ====================
    // Readout
    // ====================
    task automatic read_words(input int n);
        logic [WORD_W-1:0] held;
        logic              stalled;
        logic [31:0]       r;
        int                got;
        held    = '0;
        stalled = 1'b0;
        got     = 0;
        while (got < n) begin
            @(posedge clk);
            r = $random(seed);
            readout_trigger <= (r[1:0] != 2'b00);
            @(negedge clk);
            if (stalled) begin
                check_val(readout_ready, 1'b1, "readout_ready held during stall");
                check_val(readout_data, held, "readout_data held during stall");
            end
            stalled = readout_ready && !readout_trigger;
            held    = readout_data;
            if (readout_ready && readout_trigger) begin
                check_val(readout_data, exp_q[got], $sformatf("readout word %0d", got));
                got++;
            end
        end
        // Transfer of the last counted word happens on this edge
        @(posedge clk);
        readout_trigger <= 1'b0;
    endtask

    task automatic run_case(input case_t c);
        int lat;
        exp_q.delete();
        exp_hi = 0;
        exp_sh = 0;
        for (int i = 0; i < HDR_WORDS; i++)
            exp_q.push_back(c.hdr[HEADER_WIDTH-1-16*i -: 16]);

        skip_frame_with_cmd(c);
        drive_frame(c);

        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!status_capture_done);
        check_val(lat, 3, "done pulse latency after frame end");
        check_val(status_image_width, c.w, "image width");
        check_val(status_image_height, c.h, "image height");
        check_val(status_highlight_count, exp_hi, "highlight count");
        check_val(status_shadow_count, exp_sh, "shadow count");

        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat == 1)
                check_val(status_capture_done, 1'b0, "done pulse longer than one cycle");
        end while (!readout_ready);
        check_val((lat >= 2) && (lat <= 3), 1'b1, "readout_ready latency after done");

        if (c.abort_after > 0) begin
            read_words(c.abort_after);
        end else begin
            read_words(exp_q.size());
            repeat (3) begin
                @(negedge clk);
                check_val(readout_ready, 1'b0, "readout_ready after last word");
            end
        end
    endtask

    initial begin
        fifoIn_rst      = 1'b0;
        cmd_capture     = 1'b0;
        cmd_ram_block   = 1'b0;
        cmd_header      = '0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        load_cases();
        limit = 1000;
        for (int i = 0; i < N_CASES; i++)
            limit += 4 * case_cycles(cases[i]);

        repeat (2) @(posedge clk);
        fifoIn_rst <= 1'b1;

        // Quiet outputs straight after reset
        repeat (4) begin
            @(negedge clk);
            check_val(readout_ready, 1'b0, "readout_ready after reset");
            check_val(status_capture_done, 1'b0, "done after reset");
            check_val(status_image_width, 0, "width after reset");
            check_val(status_image_height, 0, "height after reset");
            check_val(status_highlight_count, 0, "highlight count after reset");
            check_val(status_shadow_count, 0, "shadow count after reset");
        end

        for (int i = 0; i < N_CASES; i++)
            run_case(cases[i]);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
